// ==== Makefile ====
TOP := cc_data_path_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f cc_data_path.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir

// ==== cc_data_path.f ====
rtl/cc_data_pkg.sv
rtl/cc_spill_reg.sv
rtl/cc_order_fifo.sv
rtl/cc_data_mux.sv
rtl/cc_data_router.sv
rtl/cc_data_path.sv
sim/cc_data_path_tb.sv

// ==== rtl/cc_data_mux.sv ====
// Round-robin merge of the core and FP subsystem request streams onto one port.
// Responses come back in order and are steered to the requester that issued them.

`default_nettype none

module cc_data_mux #(
  parameter int unsigned RespDepth = 4
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  // Requester side
  input  wire logic                  req_valid_i [cc_data_pkg::NumRequesters],
  output logic                       req_ready_o [cc_data_pkg::NumRequesters],
  input  wire cc_data_pkg::data_req_t req_i      [cc_data_pkg::NumRequesters],
  output logic                       rsp_valid_o [cc_data_pkg::NumRequesters],
  input  wire logic                  rsp_ready_i [cc_data_pkg::NumRequesters],
  output cc_data_pkg::data_rsp_t     rsp_o,
  // Merged side
  output logic                       req_valid_o,
  input  wire logic                  req_ready_i,
  output cc_data_pkg::data_req_t     req_o,
  input  wire logic                  rsp_valid_i,
  output logic                       rsp_ready_o,
  input  wire cc_data_pkg::data_rsp_t rsp_i
);

  cc_data_pkg::requester_t gnt, gnt_q, prio_q, ord_head;
  logic                    lock_q;
  logic                    ord_full, ord_empty;
  logic                    req_hs, rsp_hs;

  // ----------------------------------------
  // Arbitration
  // ----------------------------------------
  // Stalled grant stays put, otherwise priority requester wins if it asks
  always_comb begin
    if (lock_q) begin
      gnt = gnt_q;
    end else if (req_valid_i[prio_q]) begin
      gnt = prio_q;
    end else begin
      gnt = cc_data_pkg::requester_t'(prio_q + 1'b1);
    end
  end

  assign req_valid_o = req_valid_i[gnt] && !ord_full;
  assign req_o       = req_i[gnt];
  assign req_hs      = req_valid_o && req_ready_i;

  always_comb begin
    for (int i = 0; i < cc_data_pkg::NumRequesters; i++) begin
      req_ready_o[i] = (gnt == cc_data_pkg::requester_t'(i)) && req_ready_i && !ord_full;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q <= '0;
      gnt_q  <= '0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= req_valid_o && !req_ready_i;
      gnt_q  <= gnt;
      if (req_hs) begin
        prio_q <= cc_data_pkg::requester_t'(gnt + 1'b1);
      end
    end
  end

  // ----------------------------------------
  // Response steering
  // ----------------------------------------
  assign rsp_hs      = rsp_valid_i && rsp_ready_o;
  assign rsp_ready_o = !ord_empty && rsp_ready_i[ord_head];
  assign rsp_o       = rsp_i;

  always_comb begin
    for (int i = 0; i < cc_data_pkg::NumRequesters; i++) begin
      rsp_valid_o[i] = rsp_valid_i && !ord_empty
                       && (ord_head == cc_data_pkg::requester_t'(i));
    end
  end

  cc_order_fifo #(
    .Depth (RespDepth),
    .T     (cc_data_pkg::requester_t)
  ) i_order_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (req_hs),
    .data_i  (gnt),
    .pop_i   (rsp_hs),
    .data_o  (ord_head),
    .full_o  (ord_full),
    .empty_o (ord_empty)
  );

  // Requesters hold valid and payload until the request is taken
  for (genvar i = 0; i < cc_data_pkg::NumRequesters; i++) begin : gen_req_stable
    req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
      req_valid_i[i] && !req_ready_o[i] |=> req_valid_i[i] && $stable(req_i[i]))
      else $error("requester dropped or changed a pending request");
  end

endmodule

`default_nettype wire

// ==== rtl/cc_data_path.sv ====
// Top level of the data-port path: merge of the two requesters, optional
// request/response cuts, and TCDM/SoC routing.

`default_nettype none

module cc_data_path #(
  parameter int unsigned        TcdmAddrWidth = 17,
  parameter bit                 AliasEnable   = 1'b0,
  parameter cc_data_pkg::addr_t AliasBase     = '0,
  parameter int unsigned        RespDepth     = 4,
  parameter bit                 RegisterReq   = 1'b1,
  parameter bit                 RegisterRsp   = 1'b1
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire cc_data_pkg::addr_t     tcdm_base_i,
  // Requesters, index 0 core and index 1 FP subsystem
  input  wire logic                   req_valid_i [cc_data_pkg::NumRequesters],
  output logic                        req_ready_o [cc_data_pkg::NumRequesters],
  input  wire cc_data_pkg::data_req_t req_i       [cc_data_pkg::NumRequesters],
  output logic                        rsp_valid_o [cc_data_pkg::NumRequesters],
  input  wire logic                   rsp_ready_i [cc_data_pkg::NumRequesters],
  output cc_data_pkg::data_rsp_t      rsp_o,
  // TCDM port
  output logic                        tcdm_req_valid_o,
  input  wire logic                   tcdm_req_ready_i,
  output cc_data_pkg::data_req_t      tcdm_req_o,
  input  wire logic                   tcdm_rsp_valid_i,
  output logic                        tcdm_rsp_ready_o,
  input  wire cc_data_pkg::data_rsp_t tcdm_rsp_i,
  // SoC port
  output logic                        soc_req_valid_o,
  input  wire logic                   soc_req_ready_i,
  output cc_data_pkg::data_req_t      soc_req_o,
  input  wire logic                   soc_rsp_valid_i,
  output logic                        soc_rsp_ready_o,
  input  wire cc_data_pkg::data_rsp_t soc_rsp_i
);

  // Mux to request cut, and response cut back to mux
  logic                   mux_req_valid, mux_req_ready;
  cc_data_pkg::data_req_t mux_req;
  logic                   mux_rsp_valid, mux_rsp_ready;
  cc_data_pkg::data_rsp_t mux_rsp;
  // Cuts to router
  logic                   rtr_req_valid, rtr_req_ready;
  cc_data_pkg::data_req_t rtr_req;
  logic                   rtr_rsp_valid, rtr_rsp_ready;
  cc_data_pkg::data_rsp_t rtr_rsp;

  cc_data_mux #(
    .RespDepth (RespDepth)
  ) i_mux (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o),
    .req_valid_o (mux_req_valid),
    .req_ready_i (mux_req_ready),
    .req_o       (mux_req),
    .rsp_valid_i (mux_rsp_valid),
    .rsp_ready_o (mux_rsp_ready),
    .rsp_i       (mux_rsp)
  );

  cc_spill_reg #(
    .T      (cc_data_pkg::data_req_t),
    .Bypass (!RegisterReq)
  ) i_req_cut (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (mux_req_valid),
    .ready_o (mux_req_ready),
    .data_i  (mux_req),
    .valid_o (rtr_req_valid),
    .ready_i (rtr_req_ready),
    .data_o  (rtr_req)
  );

  cc_spill_reg #(
    .T      (cc_data_pkg::data_rsp_t),
    .Bypass (!RegisterRsp)
  ) i_rsp_cut (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (rtr_rsp_valid),
    .ready_o (rtr_rsp_ready),
    .data_i  (rtr_rsp),
    .valid_o (mux_rsp_valid),
    .ready_i (mux_rsp_ready),
    .data_o  (mux_rsp)
  );

  cc_data_router #(
    .TcdmAddrWidth (TcdmAddrWidth),
    .AliasEnable   (AliasEnable),
    .AliasBase     (AliasBase),
    .RespDepth     (RespDepth)
  ) i_router (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .tcdm_base_i      (tcdm_base_i),
    .req_valid_i      (rtr_req_valid),
    .req_ready_o      (rtr_req_ready),
    .req_i            (rtr_req),
    .rsp_valid_o      (rtr_rsp_valid),
    .rsp_ready_i      (rtr_rsp_ready),
    .rsp_o            (rtr_rsp),
    .tcdm_req_valid_o (tcdm_req_valid_o),
    .tcdm_req_ready_i (tcdm_req_ready_i),
    .tcdm_req_o       (tcdm_req_o),
    .tcdm_rsp_valid_i (tcdm_rsp_valid_i),
    .tcdm_rsp_ready_o (tcdm_rsp_ready_o),
    .tcdm_rsp_i       (tcdm_rsp_i),
    .soc_req_valid_o  (soc_req_valid_o),
    .soc_req_ready_i  (soc_req_ready_i),
    .soc_req_o        (soc_req_o),
    .soc_rsp_valid_i  (soc_rsp_valid_i),
    .soc_rsp_ready_o  (soc_rsp_ready_o),
    .soc_rsp_i        (soc_rsp_i)
  );

endmodule

`default_nettype wire

// ==== rtl/cc_data_pkg.sv ====
// Shared widths, payload structs and encodings for the core-complex data path.
// Used by scoped name from every RTL module and the testbench.

`default_nettype none

package cc_data_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;
  // Collective mask carried alongside each request
  localparam int unsigned CollWidth = 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [CollWidth-1:0] coll_t;

  // ----------------------------------------
  // Channel payloads
  // ----------------------------------------
  // Request, 77 bits
  typedef struct packed {
    addr_t addr;
    logic  write;
    data_t data;
    strb_t strb;
    coll_t coll;
  } data_req_t;

  // Response, 33 bits
  typedef struct packed {
    data_t data;
    logic  error;
  } data_rsp_t;

  // ----------------------------------------
  // Routing and requesters
  // ----------------------------------------
  typedef enum logic {
    TargetSoc  = 1'b0,
    TargetTcdm = 1'b1
  } target_e;

  localparam int unsigned NumRequesters = 2;

  // Index 0 is the integer core, index 1 the FP subsystem
  typedef logic [$clog2(NumRequesters)-1:0] requester_t;

endpackage

`default_nettype wire

// ==== rtl/cc_data_router.sv ====
// Routes the merged request stream to the TCDM or the SoC port by address.
// Collective requests always go to the SoC; responses are collected in issue order.

`default_nettype none

module cc_data_router #(
  parameter int unsigned        TcdmAddrWidth = 17,
  parameter bit                 AliasEnable   = 1'b0,
  parameter cc_data_pkg::addr_t AliasBase     = '0,
  parameter int unsigned        RespDepth     = 4
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire cc_data_pkg::addr_t     tcdm_base_i,
  // Merged stream
  input  wire logic                   req_valid_i,
  output logic                        req_ready_o,
  input  wire cc_data_pkg::data_req_t req_i,
  output logic                        rsp_valid_o,
  input  wire logic                   rsp_ready_i,
  output cc_data_pkg::data_rsp_t      rsp_o,
  // TCDM port
  output logic                        tcdm_req_valid_o,
  input  wire logic                   tcdm_req_ready_i,
  output cc_data_pkg::data_req_t      tcdm_req_o,
  input  wire logic                   tcdm_rsp_valid_i,
  output logic                        tcdm_rsp_ready_o,
  input  wire cc_data_pkg::data_rsp_t tcdm_rsp_i,
  // SoC port
  output logic                        soc_req_valid_o,
  input  wire logic                   soc_req_ready_i,
  output cc_data_pkg::data_req_t      soc_req_o,
  input  wire logic                   soc_rsp_valid_i,
  output logic                        soc_rsp_ready_o,
  input  wire cc_data_pkg::data_rsp_t soc_rsp_i
);

  // Bits above the window size identify the window
  localparam cc_data_pkg::addr_t WinMask = {cc_data_pkg::AddrWidth{1'b1}} << TcdmAddrWidth;

  cc_data_pkg::target_e sel, ord_head;
  logic                 in_tcdm, in_alias, sel_ready;
  logic                 ord_full, ord_empty;
  logic                 req_hs, rsp_hs;

  // ----------------------------------------
  // Target decode
  // ----------------------------------------
  assign in_tcdm  = (req_i.addr & WinMask) == (tcdm_base_i & WinMask);
  assign in_alias = AliasEnable && ((req_i.addr & WinMask) == (AliasBase & WinMask));

  // Collectives are resolved outside the cluster, so they never take the TCDM path
  always_comb begin
    if (req_i.coll != '0) begin
      sel = cc_data_pkg::TargetSoc;
    end else if (in_tcdm || in_alias) begin
      sel = cc_data_pkg::TargetTcdm;
    end else begin
      sel = cc_data_pkg::TargetSoc;
    end
  end

  // ----------------------------------------
  // Request demux
  // ----------------------------------------
  assign sel_ready   = (sel == cc_data_pkg::TargetTcdm) ? tcdm_req_ready_i : soc_req_ready_i;
  assign req_ready_o = sel_ready && !ord_full;
  assign req_hs      = req_valid_i && req_ready_o;

  assign tcdm_req_valid_o = req_valid_i && !ord_full && (sel == cc_data_pkg::TargetTcdm);
  assign soc_req_valid_o  = req_valid_i && !ord_full && (sel == cc_data_pkg::TargetSoc);
  assign tcdm_req_o       = req_i;
  assign soc_req_o        = req_i;

  // ----------------------------------------
  // Response collection
  // ----------------------------------------
  // Only the target at the FIFO head may answer
  always_comb begin
    if (ord_head == cc_data_pkg::TargetTcdm) begin
      rsp_valid_o = !ord_empty && tcdm_rsp_valid_i;
      rsp_o       = tcdm_rsp_i;
    end else begin
      rsp_valid_o = !ord_empty && soc_rsp_valid_i;
      rsp_o       = soc_rsp_i;
    end
  end

  assign tcdm_rsp_ready_o = !ord_empty && (ord_head == cc_data_pkg::TargetTcdm) && rsp_ready_i;
  assign soc_rsp_ready_o  = !ord_empty && (ord_head == cc_data_pkg::TargetSoc) && rsp_ready_i;
  assign rsp_hs           = rsp_valid_o && rsp_ready_i;

  cc_order_fifo #(
    .Depth (RespDepth),
    .T     (cc_data_pkg::target_e)
  ) i_order_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (req_hs),
    .data_i  (sel),
    .pop_i   (rsp_hs),
    .data_o  (ord_head),
    .full_o  (ord_full),
    .empty_o (ord_empty)
  );

  // Targets answer only requests they were sent
  no_orphan_rsp : assert property (@(posedge clk_i) disable iff (!rst_ni)
    tcdm_rsp_valid_i || soc_rsp_valid_i |-> !ord_empty)
    else $error("target response with no request outstanding");

endmodule

`default_nettype wire

// ==== rtl/cc_order_fifo.sv ====
// Small circular FIFO that records, for each outstanding request, where its
// response is expected from. Push and pop are gated by the user with full/empty.

`default_nettype none

module cc_order_fifo #(
  parameter int unsigned Depth = 4,
  parameter type         T     = logic
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic push_i,
  input  wire T     data_i,
  input  wire logic pop_i,
  output T          data_o,
  output logic      full_o,
  output logic      empty_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  T                    mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] cnt_q;

  assign full_o  = (cnt_q == CntWidth'(Depth));
  assign empty_o = (cnt_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  // Pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_i && !push_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    full_o |-> !push_i)
    else $error("order FIFO pushed while full");

  no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    empty_o |-> !pop_i)
    else $error("order FIFO popped while empty");

endmodule

`default_nettype wire

// ==== rtl/cc_spill_reg.sv ====
// Two-entry valid/ready spill register that cuts all paths between its ports.
// The payload type is a parameter; with Bypass set the channel passes straight through.

`default_nettype none

module cc_spill_reg #(
  parameter type T      = logic,
  parameter bit  Bypass = 1'b0
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic valid_i,
  output logic      ready_o,
  input  wire T     data_i,
  output logic      valid_o,
  input  wire logic ready_i,
  output T          data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    // Slot a takes new items, slot b holds the older item on a stall
    T     a_data_q, b_data_q;
    logic a_full_q, b_full_q;
    logic a_fill, a_drain, b_fill, b_drain;

    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // Older item leaves first
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;
    assign ready_o = !a_full_q || !b_full_q;

    // Held output must not change until it is taken
    stable_out : assert property (@(posedge clk_i) disable iff (!rst_ni)
      valid_o && !ready_i |=> valid_o && $stable(data_o))
      else $error("spill register output changed while stalled");
  end

endmodule

`default_nettype wire

// ==== sim/cc_data_path_cases.txt ====
// Columns: requester _ write _ address _ write data _ collective mask _ target (1 TCDM, 0 SoC)
// Requester 0 uses data tag c0, requester 1 tag f1; address sets are disjoint
0_1_10000040_c0000001_00_1
1_1_10000140_f1000001_00_1
0_0_10000040_00000000_00_1
1_0_10000140_00000000_00_1
0_1_80000040_c0000002_00_0
1_1_80000140_f1000002_00_0
0_0_80000040_00000000_00_0
1_0_80000144_00000000_00_0
0_1_00100040_c0000003_00_1
1_0_00100140_00000000_00_1
0_0_00100040_00000000_00_1
1_1_1001fff0_f1000003_00_1
0_0_10020040_00000000_00_0
1_1_10000180_f1000004_03_0
0_0_10000080_00000000_80_0
1_0_10000180_00000000_00_1
0_1_10000084_c0000005_00_1
1_0_1001fff0_00000000_00_1
0_0_10000084_00000000_00_1
1_0_00000140_00000000_00_0

// ==== sim/cc_data_path_tb.sv ====
// Testbench for the data-port path. Reads requests from the cases file, drives
// both requesters at once and models the TCDM and SoC as in-order memories.

`default_nettype none

module cc_data_path_tb;

  localparam int unsigned MaxCases = 64;
  localparam int          Period   = 100;

  logic clk_i;
  logic rst_ni;
  logic req_valid [2];
  logic req_ready [2];
  logic rsp_valid [2];
  logic rsp_ready [2];
  cc_data_pkg::data_req_t req [2];
  cc_data_pkg::data_rsp_t rsp;
  // Target ports indexed by target_e value
  logic                   t_req_valid [2];
  logic                   t_req_ready [2];
  cc_data_pkg::data_req_t t_req [2];
  logic                   t_rsp_valid [2];
  logic                   t_rsp_ready [2];
  cc_data_pkg::data_rsp_t t_rsp [2];

  // Case word holds requester, write, addr, wdata, coll and expected target
  logic [83:0] cases_mem [MaxCases];
  int          ncases;
  integer      seed = 32'h7f31b99d;
  int          val_errs;
  int          misc_errs;
  int          req_count;
  int          rsp_count;
  int          last_gnt = -1;

  cc_data_pkg::data_req_t sent_q [2][$];
  cc_data_pkg::target_e   sent_tgt [2][$];
  cc_data_pkg::data_rsp_t exp_q [2][$];
  cc_data_pkg::data_rsp_t pend_q [2][$];
  cc_data_pkg::data_t     ref_mem [logic [32:0]];
  cc_data_pkg::data_t     tgt_mem [logic [32:0]];

  cc_data_path #(
    .TcdmAddrWidth (17),
    .AliasEnable   (1'b1),
    .AliasBase     (32'h0010_0000),
    .RespDepth     (4),
    .RegisterReq   (1'b1),
    .RegisterRsp   (1'b1)
  ) dut (
    .clk_i (clk_i), .rst_ni (rst_ni), .tcdm_base_i (32'h1000_0000),
    .req_valid_i (req_valid), .req_ready_o (req_ready), .req_i (req),
    .rsp_valid_o (rsp_valid), .rsp_ready_i (rsp_ready), .rsp_o (rsp),
    .tcdm_req_valid_o (t_req_valid[1]), .tcdm_req_ready_i (t_req_ready[1]),
    .tcdm_req_o (t_req[1]), .tcdm_rsp_valid_i (t_rsp_valid[1]),
    .tcdm_rsp_ready_o (t_rsp_ready[1]), .tcdm_rsp_i (t_rsp[1]),
    .soc_req_valid_o (t_req_valid[0]), .soc_req_ready_i (t_req_ready[0]),
    .soc_req_o (t_req[0]), .soc_rsp_valid_i (t_rsp_valid[0]),
    .soc_rsp_ready_o (t_rsp_ready[0]), .soc_rsp_i (t_rsp[0])
  );

  initial begin
    clk_i = 1'b0;
    forever #(Period / 2) clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_req(input string name, input cc_data_pkg::data_req_t got,
                           input cc_data_pkg::data_req_t exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_rsp(input string name, input cc_data_pkg::data_rsp_t got,
                           input cc_data_pkg::data_rsp_t exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_tgt(input string name, input cc_data_pkg::target_e got,
                           input cc_data_pkg::target_e exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %0d exp %0d", $time, name, got, exp);
      val_errs++;
    end
  endtask

  // Last value written, else the address XOR pattern
  function automatic cc_data_pkg::data_t read_word(input logic [32:0] key, input bit use_ref);
    if (use_ref && ref_mem.exists(key)) return ref_mem[key];
    if (!use_ref && tgt_mem.exists(key)) return tgt_mem[key];
    return key[31:0] ^ 32'h5a5a_5a5a;
  endfunction

  // ----------------------------------------
  // Requester driver
  // ----------------------------------------
  task automatic drive_requester(input int r);
    cc_data_pkg::data_req_t rq;
    cc_data_pkg::data_rsp_t ex;
    cc_data_pkg::target_e   tg;
    logic [32:0]            key;
    for (int i = 0; i < ncases; i++) begin
      if (int'(cases_mem[i][83:80]) == r) begin
        rq.addr  = cases_mem[i][75:44];
        rq.write = cases_mem[i][76];
        rq.data  = cases_mem[i][43:12];
        rq.strb  = 4'hf;
        rq.coll  = cases_mem[i][11:4];
        tg       = cc_data_pkg::target_e'(cases_mem[i][0]);
        req[r]       = rq;
        req_valid[r] = 1'b1;
        do @(posedge clk_i); while (!req_ready[r]);
        key = {tg, rq.addr};
        ex.error = 1'b0;
        ex.data  = rq.write ? '0 : read_word(key, 1'b1);
        if (rq.write) ref_mem[key] = rq.data;
        sent_q[r].push_back(rq);
        sent_tgt[r].push_back(tg);
        exp_q[r].push_back(ex);
        #1;
      end
    end
    req_valid[r] = 1'b0;
  endtask

  // ----------------------------------------
  // TCDM and SoC responder model
  // ----------------------------------------
  task automatic serve_target(input int t);
    int                     o;
    int                     cnt;
    cc_data_pkg::data_req_t got;
    cc_data_pkg::data_rsp_t r;
    logic [32:0]            key;
    string                  name;
    cnt  = 0;
    name = (t == 1) ? "tcdm_req_o" : "soc_req_o";
    forever begin
      @(posedge clk_i);
      if (t_req_valid[t] && t_req_ready[t]) begin
        got = t_req[t];
        o   = -1;
        if (sent_q[0].size() > 0 && sent_q[0][0].addr == got.addr) o = 0;
        else if (sent_q[1].size() > 0 && sent_q[1][0].addr == got.addr) o = 1;
        if (o < 0) begin
          $display("Request at %s matches no request issued by either requester", name);
          misc_errs++;
        end else begin
          check_req(name, got, sent_q[o].pop_front());
          check_tgt({name, " target"}, cc_data_pkg::target_e'(t), sent_tgt[o].pop_front());
        end
        key     = {t[0], got.addr};
        r.error = 1'b0;
        r.data  = got.write ? '0 : read_word(key, 1'b0);
        if (got.write) tgt_mem[key] = got.data;
        pend_q[t].push_back(r);
      end
      if (t_rsp_valid[t] && t_rsp_ready[t]) begin
        void'(pend_q[t].pop_front());
        cnt = $unsigned($random(seed)) % 4;
      end
      #1;
      t_req_ready[t] = ($unsigned($random(seed)) % 4) != 0;
      t_rsp_valid[t] = 1'b0;
      if (pend_q[t].size() > 0) begin
        if (cnt > 0) begin
          cnt--;
        end else begin
          t_rsp_valid[t] = 1'b1;
          t_rsp[t]       = pend_q[t][0];
        end
      end
    end
  endtask

  // ----------------------------------------
  // Requester-side monitor
  // ----------------------------------------
  initial begin
    forever begin
      @(posedge clk_i);
      if (!rst_ni || rsp_count == 0 && req_count == 0) begin
        if (rsp_valid[0] || rsp_valid[1] || t_req_valid[0] || t_req_valid[1]) begin
          $display("A DUT valid output is high during reset or before any request");
          misc_errs++;
        end
      end
      for (int r = 0; r < 2; r++) begin
        if (req_valid[r] && req_ready[r]) begin
          if (req_valid[0] && req_valid[1] && r == last_gnt) begin
            $display("Requester %0d granted twice in a row while both were waiting", r);
            misc_errs++;
          end
          last_gnt = r;
          req_count++;
        end
        if (rsp_valid[r] && rsp_ready[r]) begin
          if (exp_q[r].size() == 0) begin
            $display("Requester %0d got a response with no request outstanding", r);
            misc_errs++;
          end else begin
            check_rsp(r == 0 ? "rsp_o core" : "rsp_o fpss", rsp, exp_q[r].pop_front());
          end
          rsp_count++;
        end
      end
      #1;
      rsp_ready[0] = ($unsigned($random(seed)) % 3) != 0;
      rsp_ready[1] = ($unsigned($random(seed)) % 3) != 0;
    end
  end

  // Watchdog sized from the number of cases
  initial begin
    #1;
    #(ncases * 40 * Period);
    $display("Timeout after %0d cycles with %0d of %0d responses", ncases * 40, rsp_count,
             ncases);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    rst_ni = 1'b0;
    for (int i = 0; i < 2; i++) begin
      req_valid[i]   = 1'b0;
      req[i]         = '0;
      rsp_ready[i]   = 1'b0;
      t_req_ready[i] = 1'b0;
      t_rsp_valid[i] = 1'b0;
      t_rsp[i]       = '0;
    end
    for (int i = 0; i < MaxCases; i++) begin
      cases_mem[i] = '1;
    end
    $readmemh("sim/cc_data_path_cases.txt", cases_mem);
    ncases = 0;
    // Entries past the end of the file keep the all-ones marker
    while (ncases < MaxCases && cases_mem[ncases][83:80] != 4'hf) begin
      ncases++;
    end
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    fork
      serve_target(0);
      serve_target(1);
      drive_requester(0);
      drive_requester(1);
    join_none
    while (rsp_count < ncases) @(posedge clk_i);
    repeat (5) @(posedge clk_i);
    if (exp_q[0].size() + exp_q[1].size() + sent_q[0].size() + sent_q[1].size() != 0) begin
      $display("Requests left without a response or a target transfer");
      misc_errs++;
    end
    $display("Done: %0d cases, %0d value errors, %0d other errors", ncases, val_errs,
             misc_errs);
    if (val_errs == 0 && misc_errs == 0 && ncases > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
